/* source/pkt_fifo_defs.svh */
// Width and register map macros for the packet FIFO.
// Include wherever a width or an APB offset is needed.
`ifndef PKT_FIFO_DEFS_SVH
`define PKT_FIFO_DEFS_SVH

// Payload word width.
`define PKT_DATA_W 32

// FIFO address width, 16 entries.
`define PKT_ADDR_W 4

// APB address width.
`define PKT_APB_AW 8

`define PKT_REG_DATA   8'h00 // Non-last word.
`define PKT_REG_LAST   8'h04 // Last word of a packet.
`define PKT_REG_STATUS 8'h08 // Bit 0 full, bit 1 open packet.

`endif

/* source/pkt_fifo_pkg.sv */
// Types shared by the packet FIFO blocks.
// Ports name them with scoped names, bodies import the package.
`include "pkt_fifo_defs.svh"

package pkt_fifo_pkg;

	typedef logic [`PKT_DATA_W-1:0] pkt_data_t;
	typedef logic [`PKT_ADDR_W-1:0] fifo_addr_t;
	typedef logic [`PKT_ADDR_W:0]   fifo_ptr_t; // Includes the wrap bit.

	// Stored in memory and carried on the stream.
	typedef struct packed {
		logic      last;
		pkt_data_t data;
	} pkt_word_t;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [`PKT_APB_AW-1:0] paddr;
		pkt_data_t             pwdata;
	} apb_req_t;

	typedef struct packed {
		pkt_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

endpackage

/* source/gray_sync.sv */
// Two-flop synchronizer for a Gray pointer.
// Used once in each direction between wclk and rclk.
`timescale 1ns/1ps

module gray_sync (
	input  logic                    clk,
	input  logic                    rrst_n,
	input  pkt_fifo_pkg::fifo_ptr_t ptr_in,
	output pkt_fifo_pkg::fifo_ptr_t ptr_sync
);
	import pkt_fifo_pkg::*;

	fifo_ptr_t ptr_q1; // First stage, may go metastable.

	always_ff @(posedge clk or negedge rrst_n) begin
		if (!rrst_n) begin
			ptr_q1   <= '0;
			ptr_sync <= '0;
		end else begin
			ptr_q1   <= ptr_in;
			ptr_sync <= ptr_q1;
		end
	end

endmodule

/* source/pkt_fifo_mem.sv */
// FIFO storage, written on wclk and read asynchronously at raddr.
`timescale 1ns/1ps
`include "pkt_fifo_defs.svh"

module pkt_fifo_mem (
	input  logic                     wclk,
	input  logic                     wr_en,
	input  pkt_fifo_pkg::fifo_addr_t waddr,
	input  pkt_fifo_pkg::pkt_word_t  wr_word,
	input  pkt_fifo_pkg::fifo_addr_t raddr,
	output pkt_fifo_pkg::pkt_word_t  rd_word
);
	import pkt_fifo_pkg::*;

	pkt_word_t mem [1<<`PKT_ADDR_W];

	always_ff @(posedge wclk) begin
		if (wr_en)
			mem[waddr] <= wr_word;
	end

	assign rd_word = mem[raddr];

endmodule

/* source/apb_pkt_writer.sv */
// APB slave on wclk that turns DATA and LAST writes into FIFO writes.
// STATUS reads return the full and open-packet flags.
`timescale 1ns/1ps
`include "pkt_fifo_defs.svh"

module apb_pkt_writer (
	input  logic                   wclk,
	input  logic                   rrst_n,
	input  pkt_fifo_pkg::apb_req_t apb_req,
	output pkt_fifo_pkg::apb_rsp_t apb_rsp,
	input  logic                   wfull,
	input  logic                   wopen,
	output logic                   wr_en,
	output pkt_fifo_pkg::pkt_word_t wr_word
);
	import pkt_fifo_pkg::*;

	logic      dec_data;
	logic      dec_last;
	logic      dec_status;
	logic      setup;
	logic      access;
	logic      wr_hit;
	pkt_data_t status_word;

	assign setup  = apb_req.psel & ~apb_req.penable;
	assign access = apb_req.psel & apb_req.penable;

	// Offset is decoded in the setup phase and used in the access phase.
	always_ff @(posedge wclk or negedge rrst_n) begin
		if (!rrst_n) begin
			dec_data   <= 1'b0;
			dec_last   <= 1'b0;
			dec_status <= 1'b0;
		end else if (setup) begin
			dec_data   <= (apb_req.paddr == `PKT_REG_DATA);
			dec_last   <= (apb_req.paddr == `PKT_REG_LAST);
			dec_status <= (apb_req.paddr == `PKT_REG_STATUS);
		end
	end

	assign wr_hit      = access & apb_req.pwrite & (dec_data | dec_last);
	assign wr_en       = wr_hit & ~wfull; // Word dropped when full.
	assign status_word = {{(`PKT_DATA_W-2){1'b0}}, wopen, wfull};

	always_comb begin
		wr_word.last = dec_last;
		wr_word.data = apb_req.pwdata;
	end

	always_comb begin
		apb_rsp.pready  = 1'b1; // No wait states.
		apb_rsp.pslverr = wr_hit & wfull;
		if (access && !apb_req.pwrite && dec_status)
			apb_rsp.prdata = status_word;
		else
			apb_rsp.prdata = '0;
	end

endmodule

/* source/pkt_wptr_full.sv */
// Write-side pointers of the packet FIFO.
// The Gray pointer seen by the reader only moves when a packet ends.
`timescale 1ns/1ps
`include "pkt_fifo_defs.svh"

module pkt_wptr_full (
	input  logic                    wclk,
	input  logic                    rrst_n,
	input  logic                    wr_en,
	input  logic                    wr_last,
	input  pkt_fifo_pkg::fifo_ptr_t wq2_rptr,
	output pkt_fifo_pkg::fifo_addr_t waddr,
	output pkt_fifo_pkg::fifo_ptr_t wptr_commit,
	output logic                    wfull,
	output logic                    wopen
);
	import pkt_fifo_pkg::*;

	fifo_ptr_t wbin;
	fifo_ptr_t wgray;
	fifo_ptr_t wbin_next;
	fifo_ptr_t wgray_next;
	fifo_ptr_t rptr_full;

	assign wbin_next  = wbin + {{`PKT_ADDR_W{1'b0}}, wr_en};
	assign wgray_next = (wbin_next >> 1) ^ wbin_next;

	// Read pointer as it looks one lap behind.
	assign rptr_full = {~wq2_rptr[`PKT_ADDR_W:`PKT_ADDR_W-1], wq2_rptr[`PKT_ADDR_W-2:0]};

	always_ff @(posedge wclk or negedge rrst_n) begin
		if (!rrst_n) begin
			wbin        <= '0;
			wgray       <= '0;
			wptr_commit <= '0;
			wfull       <= 1'b0;
		end else begin
			wbin  <= wbin_next;
			wgray <= wgray_next;
			wfull <= (wgray_next == rptr_full); // Counts uncommitted words too.
			if (wr_en && wr_last)
				wptr_commit <= wgray_next; // Publish the whole packet.
		end
	end

	assign waddr = wbin[`PKT_ADDR_W-1:0];
	assign wopen = (wgray != wptr_commit);

endmodule

/* source/pkt_rptr_empty.sv */
// Read-side pointers of the packet FIFO.
// Empty is judged against the committed write pointer only.
`timescale 1ns/1ps
`include "pkt_fifo_defs.svh"

module pkt_rptr_empty (
	input  logic                    rclk,
	input  logic                    rrst_n,
	input  logic                    rinc,
	input  pkt_fifo_pkg::fifo_ptr_t rq2_wptr,
	output pkt_fifo_pkg::fifo_addr_t raddr,
	output pkt_fifo_pkg::fifo_ptr_t rptr,
	output logic                    rempty
);
	import pkt_fifo_pkg::*;

	fifo_ptr_t rbin;
	fifo_ptr_t rgray;
	fifo_ptr_t rbin_next;
	fifo_ptr_t rgray_next;

	assign rbin_next  = rbin + {{`PKT_ADDR_W{1'b0}}, rinc & ~rempty};
	assign rgray_next = (rbin_next >> 1) ^ rbin_next;

	always_ff @(posedge rclk or negedge rrst_n) begin
		if (!rrst_n) begin
			rbin   <= '0;
			rgray  <= '0;
			rempty <= 1'b1;
		end else begin
			rbin   <= rbin_next;
			rgray  <= rgray_next;
			rempty <= (rgray_next == rq2_wptr);
		end
	end

	assign raddr = rbin[`PKT_ADDR_W-1:0];
	assign rptr  = rgray;

endmodule

/* source/axis_pkt_reader.sv */
// One-entry output register that drains the FIFO onto a valid/ready stream.
// The word is held steady while the sink stalls.
`timescale 1ns/1ps

module axis_pkt_reader (
	input  logic                    rclk,
	input  logic                    rrst_n,
	input  logic                    rempty,
	input  pkt_fifo_pkg::pkt_word_t rd_word,
	output logic                    rinc,
	output logic                    m_valid,
	input  logic                    m_ready,
	output pkt_fifo_pkg::pkt_word_t m_word
);

	logic load;

	// Free now, or freed by the transfer in this cycle.
	assign load = ~rempty & (~m_valid | m_ready);
	assign rinc = load;

	always_ff @(posedge rclk or negedge rrst_n) begin
		if (!rrst_n)
			m_valid <= 1'b0;
		else if (load)
			m_valid <= 1'b1;
		else if (m_ready)
			m_valid <= 1'b0;
	end

	always_ff @(posedge rclk) begin
		if (load)
			m_word <= rd_word;
	end

endmodule

/* source/axis_packet_fifo_async.sv */
// Packet FIFO from an APB writer on wclk to a stream on rclk.
// Only whole packets become visible to the reader.
`timescale 1ns/1ps

module axis_packet_fifo_async (
	input  logic                    wclk,
	input  logic                    rclk,
	input  logic                    rrst_n,
	input  pkt_fifo_pkg::apb_req_t  apb_req,
	output pkt_fifo_pkg::apb_rsp_t  apb_rsp,
	output logic                    m_valid,
	input  logic                    m_ready,
	output pkt_fifo_pkg::pkt_word_t m_word
);
	import pkt_fifo_pkg::*;

	logic       wr_en;
	pkt_word_t  wr_word;
	pkt_word_t  rd_word;
	logic       wfull;
	logic       wopen;
	logic       rempty;
	logic       rinc;
	fifo_addr_t waddr;
	fifo_addr_t raddr;
	fifo_ptr_t  wptr_commit;
	fifo_ptr_t  rptr;
	fifo_ptr_t  wq2_rptr;
	fifo_ptr_t  rq2_wptr;

	apb_pkt_writer u_apb_pkt_writer (
		.wclk    (wclk),
		.rrst_n  (rrst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.wfull   (wfull),
		.wopen   (wopen),
		.wr_en   (wr_en),
		.wr_word (wr_word)
	);

	pkt_wptr_full u_pkt_wptr_full (
		.wclk        (wclk),
		.rrst_n      (rrst_n),
		.wr_en       (wr_en),
		.wr_last     (wr_word.last),
		.wq2_rptr    (wq2_rptr),
		.waddr       (waddr),
		.wptr_commit (wptr_commit),
		.wfull       (wfull),
		.wopen       (wopen)
	);

	gray_sync u_sync_w2r (
		.clk      (rclk),
		.rrst_n   (rrst_n),
		.ptr_in   (wptr_commit),
		.ptr_sync (rq2_wptr)
	);

	gray_sync u_sync_r2w (
		.clk      (wclk),
		.rrst_n   (rrst_n),
		.ptr_in   (rptr),
		.ptr_sync (wq2_rptr)
	);

	pkt_fifo_mem u_pkt_fifo_mem (
		.wclk    (wclk),
		.wr_en   (wr_en),
		.waddr   (waddr),
		.wr_word (wr_word),
		.raddr   (raddr),
		.rd_word (rd_word)
	);

	pkt_rptr_empty u_pkt_rptr_empty (
		.rclk     (rclk),
		.rrst_n   (rrst_n),
		.rinc     (rinc),
		.rq2_wptr (rq2_wptr),
		.raddr    (raddr),
		.rptr     (rptr),
		.rempty   (rempty)
	);

	axis_pkt_reader u_axis_pkt_reader (
		.rclk    (rclk),
		.rrst_n  (rrst_n),
		.rempty  (rempty),
		.rd_word (rd_word),
		.rinc    (rinc),
		.m_valid (m_valid),
		.m_ready (m_ready),
		.m_word  (m_word)
	);

endmodule

/* tb/pkt_fifo_properties.sv */
// Port protocol checks for the packet FIFO, bound to the top level.
// Stream checks run on rclk and APB checks on wclk.
`timescale 1ns/1ps

module pkt_fifo_properties (
	input logic                    wclk,
	input logic                    rclk,
	input logic                    rrst_n,
	input pkt_fifo_pkg::apb_req_t  apb_req,
	input pkt_fifo_pkg::apb_rsp_t  apb_rsp,
	input logic                    m_valid,
	input logic                    m_ready,
	input pkt_fifo_pkg::pkt_word_t m_word
);

	int failures = 0;

	// A stalled word stays on the stream.
	stream_hold: assert property (@(posedge rclk) disable iff (!rrst_n)
		m_valid && !m_ready |=> m_valid && $stable(m_word))
	else begin
		failures++;
		$error("m_valid or m_word changed while m_ready was low");
	end

	stream_reset: assert property (@(posedge rclk) !rrst_n || $past(!rrst_n) |-> !m_valid)
	else begin
		failures++;
		$error("m_valid was high during or right after reset");
	end

	apb_reset: assert property (@(posedge wclk) !rrst_n || $past(!rrst_n) |-> !apb_rsp.pslverr)
	else begin
		failures++;
		$error("pslverr was high during or right after reset");
	end

	apb_ready: assert property (@(posedge wclk) disable iff (!rrst_n)
		apb_req.psel && apb_req.penable |-> apb_rsp.pready)
	else begin
		failures++;
		$error("pready was low in an APB access cycle");
	end

	// Errors only answer write accesses.
	apb_err_write: assert property (@(posedge wclk)
		apb_rsp.pslverr |-> apb_req.psel && apb_req.penable && apb_req.pwrite)
	else begin
		failures++;
		$error("pslverr was high outside a write access cycle");
	end

endmodule

bind axis_packet_fifo_async pkt_fifo_properties u_pkt_fifo_properties (.*);

/* tb/tb_axis_packet_fifo_async.sv */
// Testbench for the packet FIFO: APB packet writes on wclk, stream checks on rclk.
// Simulate it as the top module together with the bound port properties.
`timescale 1ns/1ps
`include "pkt_fifo_defs.svh"

module tb_axis_packet_fifo_async;
	import pkt_fifo_pkg::*;

	localparam int MAX_WORDS      = 150; // Bound on words over all phases.
	localparam int TIMEOUT_CYCLES = 40 * MAX_WORDS + 2000;

	logic        wclk;
	logic        rclk;
	logic        rrst_n;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        m_valid;
	logic        m_ready;
	pkt_word_t   m_word;
	int unsigned rand_state = 34121;
	int          ready_mode = 2; // 0 stall, 1 random, 2 always ready.
	pkt_word_t   exp_q[$];
	int          pending = 0;    // Accepted words of the open packet.
	int          committed = 0;  // Committed words not yet transferred.
	int          errors = 0;
	int          written = 0;
	int          received = 0;
	int          wclk_cycles = 0;

	axis_packet_fifo_async u_axis_packet_fifo_async (.*);

	initial begin
		wclk = 1'b0;
		forever #20 wclk = ~wclk;
	end

	initial begin
		rclk = 1'b0;
		#7;
		forever #28 rclk = ~rclk;
	end

	function automatic int unsigned next_rand();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state >> 8;
	endfunction

	always @(negedge rclk) begin
		case (ready_mode)
			0: m_ready = 1'b0;
			1: m_ready = (next_rand() % 10) < 7;
			default: m_ready = 1'b1;
		endcase
	end

	// Scoreboard and packet atomicity on the stream side.
	always @(posedge rclk) begin
		if (rrst_n && m_valid) begin
			assert (committed > 0)
			else begin
				errors++;
				$display("Error at time %0t: m_valid high with no committed packet", $time);
			end
		end
		if (rrst_n && m_valid && m_ready) begin
			received++;
			assert (exp_q.size() > 0)
			else begin
				errors++;
				$display("Error at time %0t: unexpected stream word %h", $time, m_word);
			end
			if (exp_q.size() > 0) begin
				assert (m_word == exp_q[0])
				else begin
					errors++;
					$display("Error at time %0t: stream word %h, expected %h",
						$time, m_word, exp_q[0]);
				end
				void'(exp_q.pop_front());
				committed--;
			end
		end
	end

	initial begin
		while (wclk_cycles < TIMEOUT_CYCLES) begin
			@(posedge wclk);
			wclk_cycles++;
		end
		$display("Timeout: the run did not finish within %0d wclk cycles", TIMEOUT_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	// One APB transfer: setup, access, then an idle cycle.
	task automatic reg_access(input logic write, input logic [`PKT_APB_AW-1:0] addr,
		input pkt_data_t wdata, output pkt_data_t rdata, output logic slverr);
		@(negedge wclk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge wclk);
		apb_req.penable = 1'b1;
		@(posedge wclk);
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(negedge wclk);
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic send_word(input logic last, input logic expect_err);
		pkt_word_t word;
		pkt_data_t rdata;
		logic      slverr;
		word.last = last;
		word.data = next_rand() ^ (next_rand() << 16);
		reg_access(1'b1, last ? `PKT_REG_LAST : `PKT_REG_DATA, word.data, rdata, slverr);
		assert (slverr == expect_err)
		else begin
			errors++;
			$display("Error at time %0t: pslverr %b, expected %b", $time, slverr, expect_err);
		end
		if (!slverr) begin
			exp_q.push_back(word);
			written++;
			pending++;
			if (last) begin
				committed += pending;
				pending = 0;
			end
		end
	endtask

	task automatic send_packet(input int len, input int max_gap);
		for (int i = 0; i < len; i++) begin
			repeat (next_rand() % (max_gap + 1)) @(negedge wclk);
			send_word(i == len - 1, 1'b0);
		end
	endtask

	task automatic check_status(input int bit_idx, input logic expected);
		pkt_data_t rdata;
		logic      slverr;
		reg_access(1'b0, `PKT_REG_STATUS, '0, rdata, slverr);
		assert (rdata[bit_idx] == expected && !slverr)
		else begin
			errors++;
			$display("Error at time %0t: STATUS bit %0d is %b, expected %b",
				$time, bit_idx, rdata[bit_idx], expected);
		end
	endtask

	task automatic wait_drained();
		ready_mode = 2;
		while (exp_q.size() != 0)
			@(negedge wclk);
		repeat (8) @(negedge wclk); // Lets the read pointer reach the writer.
	endtask

	initial begin
		rrst_n  = 1'b0;
		apb_req = '0;
		m_ready = 1'b0;
		repeat (10) @(posedge wclk);
		#10 rrst_n = 1'b1; // Clear of the edges of both clocks.

		// Slow packet, open bit seen while its words wait.
		send_word(1'b0, 1'b0);
		check_status(1, 1'b1);
		repeat (30) @(negedge wclk);
		send_word(1'b0, 1'b0);
		repeat (30) @(negedge wclk);
		send_word(1'b1, 1'b0);
		check_status(1, 1'b0);
		wait_drained();

		ready_mode = 1;
		for (int p = 0; p < 24; p++) begin
			while (exp_q.size() > 8)
				@(negedge wclk);
			send_packet(1 + next_rand() % 5, 3);
		end
		wait_drained();

		// Stall the sink, fill 16 entries behind the output register.
		ready_mode = 0;
		send_packet(1, 0);
		while (!m_valid)
			@(negedge rclk);
		repeat (6) @(negedge wclk);
		repeat (4) send_packet(4, 0);
		check_status(0, 1'b1);
		send_word(1'b0, 1'b1);
		wait_drained();
		repeat (10) @(negedge rclk);

		// The refused word leaves neither an open packet nor a full flag.
		check_status(0, 1'b0);
		check_status(1, 1'b0);

		errors += u_axis_packet_fifo_async.u_pkt_fifo_properties.failures;
		$display("Words written: %0d, words received: %0d, errors: %0d",
			written, received, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+source
source/pkt_fifo_pkg.sv
source/gray_sync.sv
source/pkt_fifo_mem.sv
source/apb_pkt_writer.sv
source/pkt_wptr_full.sv
source/pkt_rptr_empty.sv
source/axis_pkt_reader.sv
source/axis_packet_fifo_async.sv
tb/pkt_fifo_properties.sv
tb/tb_axis_packet_fifo_async.sv

/* Bender.yml */
package:
  name: axis_packet_fifo_async

sources:
  - include_dirs:
      - source
    files:
      - source/pkt_fifo_pkg.sv
      - source/gray_sync.sv
      - source/pkt_fifo_mem.sv
      - source/apb_pkt_writer.sv
      - source/pkt_wptr_full.sv
      - source/pkt_rptr_empty.sv
      - source/axis_pkt_reader.sv
      - source/axis_packet_fifo_async.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/pkt_fifo_properties.sv
      - tb/tb_axis_packet_fifo_async.sv
